/* flist.f */
src/axi_pkg.sv
src/axi_arbiter.sv
src/icache_refill.sv
src/dcache_bus_unit.sv
src/axi_sram.sv
src/mem_subsystem_top.sv
test/tb_clock_gen.sv
test/tb_mem_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_mem_subsystem -o sim_mem_subsystem \
    && ./obj_dir/sim_mem_subsystem | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

/* src/axi_arbiter.sv */
module axi_arbiter (
    input  logic              clk,
    input  logic              i_rst_n,
    // instruction side read
    input  axi_pkg::axi_ar_t  i_iar,
    input  logic              i_iar_valid,
    output logic              o_iar_ready,
    output axi_pkg::axi_r_t   o_ir,
    output logic              o_ir_valid,
    input  logic              i_ir_ready,
    // data side read
    input  axi_pkg::axi_ar_t  i_dar,
    input  logic              i_dar_valid,
    output logic              o_dar_ready,
    output axi_pkg::axi_r_t   o_dr,
    output logic              o_dr_valid,
    input  logic              i_dr_ready,
    // data side write
    input  axi_pkg::axi_aw_t  i_daw,
    input  logic              i_daw_valid,
    output logic              o_daw_ready,
    input  axi_pkg::axi_w_t   i_dw,
    input  logic              i_dw_valid,
    output logic              o_dw_ready,
    output logic              o_db_valid,
    input  logic              i_db_ready,
    // master port
    output axi_pkg::axi_ar_t  o_ar,
    output logic              o_ar_valid,
    input  logic              i_ar_ready,
    input  axi_pkg::axi_r_t   i_r,
    input  logic              i_r_valid,
    output logic              o_r_ready,
    output axi_pkg::axi_aw_t  o_aw,
    output logic              o_aw_valid,
    input  logic              i_aw_ready,
    output axi_pkg::axi_w_t   o_w,
    output logic              o_w_valid,
    input  logic              i_w_ready,
    input  logic              i_b_valid,
    output logic              o_b_ready
);
    import axi_pkg::*;

    logic ar_sel;
    logic r_sel;

    // data side only gets the AR channel when the fetch side is idle
    assign ar_sel = ~i_iar_valid & i_dar_valid;
    assign r_sel  = i_r.id[0];

    always_comb begin
        o_ar    = ar_sel ? i_dar : i_iar;
        o_ar.id = {3'b000, ar_sel ? ID_DCACHE : ID_ICACHE};
    end

    assign o_ar_valid  = ar_sel ? i_dar_valid : i_iar_valid;
    assign o_iar_ready = i_ar_ready & ~ar_sel;
    assign o_dar_ready = i_ar_ready & ar_sel;

    // read beats go back by id
    assign o_ir       = (r_sel == ID_ICACHE) ? i_r : '0;
    assign o_ir_valid = (r_sel == ID_ICACHE) & i_r_valid;
    assign o_dr       = (r_sel == ID_DCACHE) ? i_r : '0;
    assign o_dr_valid = (r_sel == ID_DCACHE) & i_r_valid;
    assign o_r_ready  = (r_sel == ID_DCACHE) ? i_dr_ready : i_ir_ready;

    // write channels belong to the data side alone
    assign o_aw        = i_daw;
    assign o_aw_valid  = i_daw_valid;
    assign o_daw_ready = i_aw_ready;
    assign o_w         = i_dw;
    assign o_w_valid   = i_dw_valid;
    assign o_dw_ready  = i_w_ready;
    assign o_db_valid  = i_b_valid;
    assign o_b_ready   = i_db_ready;

    // a returning read beat always finds its own side waiting for it
    a_r_to_waiting_side: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_r_valid |-> o_r_ready);

endmodule

/* src/axi_pkg.sv */
package axi_pkg;

    // read address beat, 44 bits
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
    } axi_ar_t;

    // read data beat, 37 bits
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic        last;
    } axi_r_t;

    // write address beat, 40 bits
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
    } axi_aw_t;

    // write data beat, 37 bits
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        SRAM_IDLE  = 2'd0,
        SRAM_READ  = 2'd1,
        SRAM_WDATA = 2'd2,
        SRAM_WRESP = 2'd3
    } sram_state_e;

    // low bit of the read id per requester
    localparam logic ID_ICACHE = 1'b0;
    localparam logic ID_DCACHE = 1'b1;

    // one cache line, word 0 in the low bits
    typedef logic [3:0][31:0] line_t;

endpackage

/* src/axi_sram.sv */
module axi_sram #(
    parameter int LINE_WORDS = 4,
    parameter int MEM_WORDS  = 256
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  axi_pkg::axi_ar_t  i_ar,
    input  logic              i_ar_valid,
    output logic              o_ar_ready,
    output axi_pkg::axi_r_t   o_r,
    output logic              o_r_valid,
    input  logic              i_r_ready,
    input  axi_pkg::axi_aw_t  i_aw,
    input  logic              i_aw_valid,
    output logic              o_aw_ready,
    input  axi_pkg::axi_w_t   i_w,
    input  logic              i_w_valid,
    output logic              o_w_ready,
    output logic              o_b_valid,
    input  logic              i_b_ready
);
    import axi_pkg::*;

    localparam int AW    = $clog2(MEM_WORDS);
    // longest burst served is one line
    localparam int CNT_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

    logic [31:0]      mem [MEM_WORDS];
    sram_state_e      state;
    logic [AW-1:0]    addr_q;
    logic [CNT_W-1:0] len_q;
    logic [CNT_W-1:0] beat_cnt;
    logic [3:0]       id_q;
    logic             final_beat;
    logic             ar_fire;
    logic             aw_fire;
    logic             r_fire;
    logic             w_fire;

    assign o_ar_ready = (state == SRAM_IDLE);
    // a waiting read goes first
    assign o_aw_ready = (state == SRAM_IDLE) & ~i_ar_valid;
    assign o_r_valid  = (state == SRAM_READ);
    assign o_w_ready  = (state == SRAM_WDATA);
    assign o_b_valid  = (state == SRAM_WRESP);

    assign ar_fire    = i_ar_valid & o_ar_ready;
    assign aw_fire    = i_aw_valid & o_aw_ready;
    assign r_fire     = o_r_valid & i_r_ready;
    assign w_fire     = i_w_valid & o_w_ready;
    assign final_beat = (beat_cnt == len_q);

    assign o_r = '{id: id_q, data: mem[addr_q], last: final_beat};

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state    <= SRAM_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                SRAM_IDLE: begin
                    beat_cnt <= '0;
                    if (ar_fire) begin
                        state <= SRAM_READ;
                    end else if (aw_fire) begin
                        state <= SRAM_WDATA;
                    end
                end
                SRAM_READ: begin
                    if (r_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (final_beat) begin
                            state <= SRAM_IDLE;
                        end
                    end
                end
                SRAM_WDATA: begin
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (i_w.last) begin
                            state <= SRAM_WRESP;
                        end
                    end
                end
                SRAM_WRESP: begin
                    if (i_b_ready) begin
                        state <= SRAM_IDLE;
                    end
                end
                default: state <= SRAM_IDLE;
            endcase
        end
    end

    // burst address and write port
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            addr_q <= i_ar.addr[AW+1:2];
            len_q  <= i_ar.len[CNT_W-1:0];
            id_q   <= i_ar.id;
        end else if (aw_fire) begin
            addr_q <= i_aw.addr[AW+1:2];
            len_q  <= i_aw.len[CNT_W-1:0];
        end else if (r_fire || w_fire) begin
            addr_q <= addr_q + 1'b1;
        end
        if (w_fire) begin
            for (int b = 0; b < 4; b++) begin
                if (i_w.strb[b]) begin
                    mem[addr_q][8*b +: 8] <= i_w.data[8*b +: 8];
                end
            end
        end
    end

    a_wlast_on_count: assert property (@(posedge clk) disable iff (!i_rst_n)
        w_fire |-> (i_w.last == final_beat));

endmodule

/* src/dcache_bus_unit.sv */
module dcache_bus_unit #(
    parameter int LINE_WORDS = 4
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_dreq_valid,
    input  axi_pkg::mem_op_e  i_dreq_op,
    input  logic [31:0]       i_dreq_addr,
    input  axi_pkg::line_t    i_dreq_line,
    output axi_pkg::line_t    o_dresp_line,
    output logic              o_dresp_done,
    output logic              o_dreq_busy,
    output axi_pkg::axi_ar_t  o_ar,
    output logic              o_ar_valid,
    input  logic              i_ar_ready,
    input  axi_pkg::axi_r_t   i_r,
    input  logic              i_r_valid,
    output logic              o_r_ready,
    output axi_pkg::axi_aw_t  o_aw,
    output logic              o_aw_valid,
    input  logic              i_aw_ready,
    output axi_pkg::axi_w_t   o_w,
    output logic              o_w_valid,
    input  logic              i_w_ready,
    input  logic              i_b_valid,
    output logic              o_b_ready
);
    import axi_pkg::*;

    localparam logic [31:0] LINE_MASK = ~(32'(LINE_WORDS) * 32'd4 - 32'd1);
    localparam logic [7:0]  LAST_BEAT = 8'(LINE_WORDS - 1);

    logic        busy_q;
    logic        done_q;
    logic        ar_valid_q;
    logic        aw_valid_q;
    logic        w_valid_q;
    logic [7:0]  beat_cnt;
    logic [31:0] addr_q;
    line_t       line_q;
    logic        accept;
    logic        r_fire;
    logic        w_fire;

    assign accept = i_dreq_valid & ~busy_q;
    assign r_fire = i_r_valid & o_r_ready;
    assign w_fire = w_valid_q & i_w_ready;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            ar_valid_q <= 1'b0;
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
            beat_cnt   <= 8'd0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                busy_q     <= 1'b1;
                ar_valid_q <= (i_dreq_op == MEM_READ);
                aw_valid_q <= (i_dreq_op == MEM_WRITE);
                beat_cnt   <= 8'd0;
            end
            if (ar_valid_q && i_ar_ready) begin
                ar_valid_q <= 1'b0;
            end
            // data beats only start once the address is taken
            if (aw_valid_q && i_aw_ready) begin
                aw_valid_q <= 1'b0;
                w_valid_q  <= 1'b1;
            end
            if (r_fire || w_fire) begin
                beat_cnt <= beat_cnt + 8'd1;
            end
            if (r_fire && beat_cnt == LAST_BEAT) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
            if (w_fire && beat_cnt == LAST_BEAT) begin
                w_valid_q <= 1'b0;
            end
            if (i_b_valid && o_b_ready) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // one line register holds write data going out and read data coming in
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_dreq_addr & LINE_MASK;
            if (i_dreq_op == MEM_WRITE) begin
                line_q <= i_dreq_line;
            end
        end else if (r_fire) begin
            line_q <= {i_r.data, line_q[3:1]};
        end else if (w_fire) begin
            line_q <= {32'h0, line_q[3:1]};
        end
    end

    assign o_ar       = '{id: {3'b000, ID_DCACHE}, addr: addr_q, len: LAST_BEAT};
    assign o_ar_valid = ar_valid_q;
    assign o_r_ready  = busy_q;
    assign o_aw       = '{addr: addr_q, len: LAST_BEAT};
    assign o_aw_valid = aw_valid_q;
    assign o_w        = '{data: line_q[0], strb: 4'hf, last: (beat_cnt == LAST_BEAT)};
    assign o_w_valid  = w_valid_q;
    assign o_b_ready  = busy_q;

    assign o_dresp_line = line_q;
    assign o_dresp_done = done_q;
    assign o_dreq_busy  = busy_q;

    a_no_ar_aw_overlap: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_aw_valid && o_ar_valid));

endmodule

/* src/icache_refill.sv */
module icache_refill #(
    parameter int LINE_WORDS = 4
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_ifetch_valid,
    input  logic [31:0]       i_ifetch_addr,
    output axi_pkg::line_t    o_ifetch_line,
    output logic              o_ifetch_done,
    output logic              o_ifetch_busy,
    output axi_pkg::axi_ar_t  o_ar,
    output logic              o_ar_valid,
    input  logic              i_ar_ready,
    input  axi_pkg::axi_r_t   i_r,
    input  logic              i_r_valid,
    output logic              o_r_ready
);
    import axi_pkg::*;

    localparam logic [31:0] LINE_MASK = ~(32'(LINE_WORDS) * 32'd4 - 32'd1);
    localparam logic [7:0]  LAST_BEAT = 8'(LINE_WORDS - 1);

    logic        busy_q;
    logic        done_q;
    logic        ar_valid_q;
    logic [7:0]  beat_cnt;
    logic [31:0] addr_q;
    line_t       line_q;
    logic        r_fire;

    assign r_fire = i_r_valid & o_r_ready;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            ar_valid_q <= 1'b0;
            beat_cnt   <= 8'd0;
        end else begin
            done_q <= 1'b0;
            if (i_ifetch_valid && !busy_q) begin
                busy_q     <= 1'b1;
                ar_valid_q <= 1'b1;
                beat_cnt   <= 8'd0;
            end
            if (ar_valid_q && i_ar_ready) begin
                ar_valid_q <= 1'b0;
            end
            if (r_fire) begin
                beat_cnt <= beat_cnt + 8'd1;
                if (beat_cnt == LAST_BEAT) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_ifetch_valid && !busy_q) begin
            addr_q <= i_ifetch_addr & LINE_MASK;
        end
        // beats arrive lowest word first
        if (r_fire) begin
            line_q <= {i_r.data, line_q[3:1]};
        end
    end

    assign o_ar          = '{id: {3'b000, ID_ICACHE}, addr: addr_q, len: LAST_BEAT};
    assign o_ar_valid    = ar_valid_q;
    assign o_r_ready     = busy_q;
    assign o_ifetch_line = line_q;
    assign o_ifetch_done = done_q;
    assign o_ifetch_busy = busy_q;

    a_line_size: assert property (@(posedge clk) $bits(line_t) == LINE_WORDS * 32);

    a_rlast_on_count: assert property (@(posedge clk) disable iff (!i_rst_n)
        r_fire |-> (i_r.last == (beat_cnt == LAST_BEAT)));

endmodule

/* src/mem_subsystem_top.sv */
module mem_subsystem_top #(
    parameter int LINE_WORDS = 4,
    parameter int MEM_WORDS  = 256
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_ifetch_valid,
    input  logic [31:0]       i_ifetch_addr,
    output axi_pkg::line_t    o_ifetch_line,
    output logic              o_ifetch_done,
    output logic              o_ifetch_busy,
    input  logic              i_dreq_valid,
    input  axi_pkg::mem_op_e  i_dreq_op,
    input  logic [31:0]       i_dreq_addr,
    input  axi_pkg::line_t    i_dreq_line,
    output axi_pkg::line_t    o_dresp_line,
    output logic              o_dresp_done,
    output logic              o_dreq_busy
);
    import axi_pkg::*;

    // instruction side read channels
    axi_ar_t iar;
    axi_r_t  ir;
    logic    iar_valid, iar_ready, ir_valid, ir_ready;
    // data side channels
    axi_ar_t dar;
    axi_r_t  dr;
    axi_aw_t daw;
    axi_w_t  dw;
    logic    dar_valid, dar_ready, dr_valid, dr_ready;
    logic    daw_valid, daw_ready, dw_valid, dw_ready, db_valid, db_ready;
    // master port to the SRAM
    axi_ar_t ar;
    axi_r_t  r;
    axi_aw_t aw;
    axi_w_t  w;
    logic    ar_valid, ar_ready, r_valid, r_ready;
    logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;

    icache_refill #(.LINE_WORDS(LINE_WORDS)) icache_refill_inst (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_ifetch_valid(i_ifetch_valid), .i_ifetch_addr(i_ifetch_addr),
        .o_ifetch_line(o_ifetch_line), .o_ifetch_done(o_ifetch_done),
        .o_ifetch_busy(o_ifetch_busy),
        .o_ar(iar), .o_ar_valid(iar_valid), .i_ar_ready(iar_ready),
        .i_r(ir), .i_r_valid(ir_valid), .o_r_ready(ir_ready)
    );

    dcache_bus_unit #(.LINE_WORDS(LINE_WORDS)) dcache_bus_unit_inst (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_dreq_valid(i_dreq_valid), .i_dreq_op(i_dreq_op),
        .i_dreq_addr(i_dreq_addr), .i_dreq_line(i_dreq_line),
        .o_dresp_line(o_dresp_line), .o_dresp_done(o_dresp_done),
        .o_dreq_busy(o_dreq_busy),
        .o_ar(dar), .o_ar_valid(dar_valid), .i_ar_ready(dar_ready),
        .i_r(dr), .i_r_valid(dr_valid), .o_r_ready(dr_ready),
        .o_aw(daw), .o_aw_valid(daw_valid), .i_aw_ready(daw_ready),
        .o_w(dw), .o_w_valid(dw_valid), .i_w_ready(dw_ready),
        .i_b_valid(db_valid), .o_b_ready(db_ready)
    );

    axi_arbiter axi_arbiter_inst (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_iar(iar), .i_iar_valid(iar_valid), .o_iar_ready(iar_ready),
        .o_ir(ir), .o_ir_valid(ir_valid), .i_ir_ready(ir_ready),
        .i_dar(dar), .i_dar_valid(dar_valid), .o_dar_ready(dar_ready),
        .o_dr(dr), .o_dr_valid(dr_valid), .i_dr_ready(dr_ready),
        .i_daw(daw), .i_daw_valid(daw_valid), .o_daw_ready(daw_ready),
        .i_dw(dw), .i_dw_valid(dw_valid), .o_dw_ready(dw_ready),
        .o_db_valid(db_valid), .i_db_ready(db_ready),
        .o_ar(ar), .o_ar_valid(ar_valid), .i_ar_ready(ar_ready),
        .i_r(r), .i_r_valid(r_valid), .o_r_ready(r_ready),
        .o_aw(aw), .o_aw_valid(aw_valid), .i_aw_ready(aw_ready),
        .o_w(w), .o_w_valid(w_valid), .i_w_ready(w_ready),
        .i_b_valid(b_valid), .o_b_ready(b_ready)
    );

    axi_sram #(.LINE_WORDS(LINE_WORDS), .MEM_WORDS(MEM_WORDS)) axi_sram_inst (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_ar(ar), .i_ar_valid(ar_valid), .o_ar_ready(ar_ready),
        .o_r(r), .o_r_valid(r_valid), .i_r_ready(r_ready),
        .i_aw(aw), .i_aw_valid(aw_valid), .o_aw_ready(aw_ready),
        .i_w(w), .i_w_valid(w_valid), .o_w_ready(w_ready),
        .o_b_valid(b_valid), .i_b_ready(b_ready)
    );

endmodule

/* test/mem_cases.txt */
// port (0 fetch, 1 data)  op (0 read, 1 write, 2 read started with next)  address
// then word0..word3 of the line to write, zero and unused on reads
1 1 00000040 a0000000 a0000001 a0000002 a0000003
1 0 00000040 00000000 00000000 00000000 00000000
0 0 00000040 00000000 00000000 00000000 00000000
1 1 00000100 b0000000 b0000001 b0000002 b0000003
1 1 00000200 c0000000 c0000001 c0000002 c0000003
0 2 00000100 00000000 00000000 00000000 00000000
1 0 00000200 00000000 00000000 00000000 00000000
1 1 00000300 d0000000 d0000001 d0000002 d0000003
0 2 00000300 00000000 00000000 00000000 00000000
1 1 00000040 e0000000 e0000001 e0000002 e0000003
1 0 00000040 00000000 00000000 00000000 00000000
0 0 00000048 00000000 00000000 00000000 00000000
1 0 00000108 00000000 00000000 00000000 00000000
0 0 00000304 00000000 00000000 00000000 00000000
1 0 0000020c 00000000 00000000 00000000 00000000

/* test/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic o_clk
);

    // free running, starts low
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

endmodule

/* test/tb_mem_subsystem.sv */
module tb_mem_subsystem;
    import axi_pkg::*;

    localparam int LINE_WORDS = 4;
    localparam int MEM_WORDS  = 256;
    localparam int NUM_LINES  = MEM_WORDS / LINE_WORDS;
    localparam int MAX_CASES  = 32;
    localparam int CASE_WORDS = 7;
    localparam int DRIVE_DLY  = 2;

    logic        clk;
    logic        i_rst_n;
    logic        i_ifetch_valid;
    logic [31:0] i_ifetch_addr;
    line_t       o_ifetch_line;
    logic        o_ifetch_done;
    logic        o_ifetch_busy;
    logic        i_dreq_valid;
    mem_op_e     i_dreq_op;
    logic [31:0] i_dreq_addr;
    line_t       i_dreq_line;
    line_t       o_dresp_line;
    logic        o_dresp_done;
    logic        o_dreq_busy;

    // port, opcode, address and four words per case
    logic [31:0] case_mem [0:MAX_CASES*CASE_WORDS-1];
    // expected memory contents, one entry per line
    line_t       model [0:NUM_LINES-1];
    line_t       exp_line [0:1];
    logic        pending [0:1];
    logic        was_write [0:1];
    int          pend_case [0:1];
    int          num_cases;
    int          cur_case;
    int          cycle_cnt;
    int          timeout_limit;
    int          err_count;
    int          tests_passed;
    int          tests_failed;

    tb_clock_gen #(.PERIOD(40)) tb_clock_gen_inst (.o_clk(clk));

    mem_subsystem_top #(
        .LINE_WORDS(LINE_WORDS),
        .MEM_WORDS(MEM_WORDS)
    ) mem_subsystem_top_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_ifetch_valid(i_ifetch_valid),
        .i_ifetch_addr(i_ifetch_addr),
        .o_ifetch_line(o_ifetch_line),
        .o_ifetch_done(o_ifetch_done),
        .o_ifetch_busy(o_ifetch_busy),
        .i_dreq_valid(i_dreq_valid),
        .i_dreq_op(i_dreq_op),
        .i_dreq_addr(i_dreq_addr),
        .i_dreq_line(i_dreq_line),
        .o_dresp_line(o_dresp_line),
        .o_dresp_done(o_dresp_done),
        .o_dreq_busy(o_dreq_busy)
    );

    function automatic int line_index(input logic [31:0] addr);
        return int'((addr / (LINE_WORDS * 4)) % NUM_LINES);
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            err_count++;
        end
    endtask

    task automatic report_test(input string label, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("%s: ok", label);
        end else begin
            tests_failed++;
            $display("%s: failed", label);
        end
    endtask

    // drives one request and records what its reply must be
    task automatic start_case(input int idx);
        int          base;
        logic        port;
        logic [31:0] op;
        logic [31:0] addr;
        line_t       data;
        base = idx * CASE_WORDS;
        port = case_mem[base][0];
        op   = case_mem[base + 1];
        addr = case_mem[base + 2];
        for (int k = 0; k < 4; k++) begin
            data[k] = case_mem[base + 3 + k];
        end
        pending[port]   = 1'b1;
        pend_case[port] = idx;
        was_write[port] = port && (op == 32'd1);
        if (!port) begin
            i_ifetch_addr  = addr;
            i_ifetch_valid = 1'b1;
            exp_line[0]    = model[line_index(addr)];
        end else begin
            i_dreq_addr  = addr;
            i_dreq_line  = data;
            i_dreq_op    = (op == 32'd1) ? MEM_WRITE : MEM_READ;
            i_dreq_valid = 1'b1;
            if (op == 32'd1) begin
                model[line_index(addr)] = data;
            end else begin
                exp_line[1] = model[line_index(addr)];
            end
        end
    endtask

    task automatic finish_case(input int port, input int lat, input bit timed);
        int    idx;
        int    errs_before;
        string label;
        idx         = pend_case[port];
        errs_before = err_count;
        if (port == 0) begin
            check_value("o_ifetch_line", o_ifetch_line, exp_line[0]);
        end else if (!was_write[1]) begin
            check_value("o_dresp_line", o_dresp_line, exp_line[1]);
        end
        // cycles from acceptance to done, both ends counted
        if (timed && !was_write[port]) begin
            check_value("done latency", 128'(lat), 128'(LINE_WORDS + 3));
        end
        label = $sformatf("case %0d port %0d %s addr 0x%08h", idx, port,
                          was_write[port] ? "write" : "read", case_mem[idx*CASE_WORDS+2]);
        report_test(label, errs_before);
        pending[port] = 1'b0;
    endtask

    // requests are accepted on the first edge, then wait for each done pulse
    task automatic wait_group(input bit timed);
        int lat;
        lat = 1;
        while (pending[0] || pending[1]) begin
            @(posedge clk);
            #DRIVE_DLY;
            lat++;
            i_ifetch_valid = 1'b0;
            i_dreq_valid   = 1'b0;
            if (pending[0] && o_ifetch_done) begin
                finish_case(0, lat, timed);
            end
            if (pending[1] && o_dresp_done) begin
                finish_case(1, lat, timed);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin : watchdog
        @(posedge clk);
        while (cycle_cnt < timeout_limit) begin
            @(posedge clk);
        end
        $display("hang: case %0d got no done within %0d cycles", cur_case, timeout_limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        int idx;
        int errs;
        i_rst_n        = 1'b0;
        i_ifetch_valid = 1'b0;
        i_ifetch_addr  = 32'h0;
        i_dreq_valid   = 1'b0;
        i_dreq_op      = MEM_READ;
        i_dreq_addr    = 32'h0;
        i_dreq_line    = '0;
        pending[0]     = 1'b0;
        pending[1]     = 1'b0;
        err_count      = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        cur_case       = 0;
        timeout_limit  = 100;

        // entries left unloaded keep a value no port field can hold
        for (int i = 0; i < MAX_CASES * CASE_WORDS; i++) begin
            case_mem[i] = ~32'(i);
        end
        $readmemh("test/mem_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[num_cases*CASE_WORDS] <= 32'd1) begin
            num_cases++;
        end
        timeout_limit = num_cases * 40 + 100;
        if (num_cases == 0) begin
            $display("no cases could be loaded from test/mem_cases.txt");
            err_count++;
        end

        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        i_rst_n = 1'b1;

        errs = err_count;
        check_value("o_ifetch_done", 128'(o_ifetch_done), 128'(0));
        check_value("o_dresp_done", 128'(o_dresp_done), 128'(0));
        check_value("o_ifetch_busy", 128'(o_ifetch_busy), 128'(0));
        check_value("o_dreq_busy", 128'(o_dreq_busy), 128'(0));
        report_test("reset", errs);

        idx = 0;
        while (idx < num_cases) begin
            cur_case = idx;
            // opcode 2 launches this case and the next one together
            if (case_mem[idx*CASE_WORDS+1] == 32'd2 && idx + 1 < num_cases) begin
                start_case(idx);
                start_case(idx + 1);
                wait_group(1'b0);
                idx += 2;
            end else begin
                start_case(idx);
                wait_group(1'b1);
                idx += 1;
            end
        end

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
